/* hw/bpu_pkg.sv */
package bpu_pkg;

    localparam int WORD_SIZE = 32;                          // Address and data width
    localparam logic [WORD_SIZE-1:0] RESET_PC = 32'h0000_0200;  // First fetch after reset

    localparam int BTB_FRAMES   = 32;                       // Power of two only
    localparam int BTB_IDX_BITS = $clog2(BTB_FRAMES);       // Index field width
    localparam int BTB_TAG_BITS = 8;                        // Tag field width
    localparam int BTB_IGN_BITS = WORD_SIZE - BTB_TAG_BITS - BTB_IDX_BITS - 1;

    localparam int CTR_BITS = 2;                            // Fixed 2-bit counters

    localparam int RQ_DEPTH    = 4;                         // Resolve queue entries
    localparam int RQ_PTR_BITS = $clog2(RQ_DEPTH);          // Queue pointer width
    localparam int RQ_CNT_BITS = RQ_PTR_BITS + 1;           // Count reaches RQ_DEPTH

    typedef logic [WORD_SIZE-1:0] word_t;

    // MSB of the counter is the taken prediction
    typedef enum logic [CTR_BITS-1:0] {
        SNT = 2'b00,                                        // Strongly not taken
        WNT = 2'b01,                                        // Weakly not taken
        WT  = 2'b10,                                        // Weakly taken
        ST  = 2'b11                                         // Strongly taken
    } ctr_state_t;

    // PC split for BTB access, bit 0 ignored (2-byte aligned)
    typedef struct packed {
        logic [BTB_IGN_BITS-1:0] ignore;                    // Upper bits, not stored
        logic [BTB_TAG_BITS-1:0] tag;
        logic [BTB_IDX_BITS-1:0] idx;
        logic                    byte_sel;                  // Halfword offset bit
    } btb_addr_t;

    // One resolved branch from execute
    typedef struct packed {
        word_t pc;                                          // Branch address
        word_t target;                                      // Resolved target
        logic  taken;                                       // Resolved direction
    } resolve_t;

    // Queue to BTB training payload
    typedef struct packed {
        word_t pc;
        word_t target;
        logic  taken;
    } btb_update_t;

endpackage

/* hw/btb.sv */
module btb (
    input  logic                CLK,
    input  logic                nRST,
    input  bpu_pkg::word_t      lookup_pc,      // Current fetch PC
    input  logic                upd_valid,      // Training write this cycle
    input  bpu_pkg::btb_update_t upd,           // Training payload
    output logic                pred_hit_taken, // Tag hit with taken counter
    output bpu_pkg::word_t      pred_target     // Stored target of the frame
);
    import bpu_pkg::*;

    // One direct-mapped frame
    typedef struct packed {
        logic [BTB_TAG_BITS-1:0] tag;
        word_t                   target;
        ctr_state_t              ctr;
    } btb_frame_t;

    btb_frame_t [BTB_FRAMES-1:0] frames;        // Frame storage

    btb_addr_t  look_addr;                      // Decoded lookup PC
    btb_addr_t  upd_addr;                       // Decoded update PC
    btb_frame_t look_frame;                     // Frame under lookup
    btb_frame_t upd_frame;                      // Frame being trained
    btb_frame_t next_frame;                     // Value written back
    ctr_state_t next_ctr;                       // Counter after training
    logic       look_tag_hit;
    logic       upd_tag_hit;

    assign look_addr = btb_addr_t'(lookup_pc);
    assign upd_addr  = btb_addr_t'(upd.pc);

    // Lookup path, purely combinational
    assign look_frame   = frames[look_addr.idx];
    assign look_tag_hit = (look_frame.tag == look_addr.tag);
    assign pred_hit_taken = look_tag_hit && look_frame.ctr[CTR_BITS-1]; // MSB means taken
    assign pred_target    = look_frame.target;  // Driven even on a miss

    // Training frame read
    assign upd_frame   = frames[upd_addr.idx];
    assign upd_tag_hit = (upd_frame.tag == upd_addr.tag);

    // Counter move on a tag match
    always_comb begin
        case (upd_frame.ctr)
            SNT: begin
                next_ctr = upd.taken ? WNT : SNT;
            end
            WNT: begin
                next_ctr = upd.taken ? ST : SNT;    // Taken jumps straight to strong
            end
            WT: begin
                next_ctr = upd.taken ? ST : SNT;
            end
            ST: begin
                next_ctr = upd.taken ? ST : WT;
            end
            default: begin
                next_ctr = SNT;
            end
        endcase
    end

    // Frame to write back
    always_comb begin
        next_frame = upd_frame;
        if (upd_tag_hit) begin
            next_frame.target = upd.target;     // Refresh target on a hit
            next_frame.ctr    = next_ctr;
        end else begin
            next_frame.tag    = upd_addr.tag;   // Replace the aliasing entry
            next_frame.target = upd.target;
            next_frame.ctr    = upd.taken ? WT : WNT; // Weak start toward outcome
        end
    end

    // Frames come up empty with SNT counters
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            frames <= '0;
        end else if (upd_valid) begin
            frames[upd_addr.idx] <= next_frame; // One write per cycle
        end
    end

endmodule

/* hw/resolve_queue.sv */
module resolve_queue (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 in_valid,  // Resolve offered by execute
    input  bpu_pkg::resolve_t    in_data,   // Resolved branch
    output logic                 in_ready,  // Low only when full
    output logic                 upd_valid, // Head entry present
    output bpu_pkg::btb_update_t upd        // Head entry for the BTB
);
    import bpu_pkg::*;

    resolve_t                mem [RQ_DEPTH];    // Entry storage
    logic [RQ_PTR_BITS-1:0]  wr_ptr;            // Next free slot
    logic [RQ_PTR_BITS-1:0]  rd_ptr;            // Oldest entry
    logic [RQ_CNT_BITS-1:0]  count;             // Entries held
    logic                    push;
    logic                    pop;
    resolve_t                head;

    assign in_ready  = (count != RQ_CNT_BITS'(RQ_DEPTH));
    assign upd_valid = (count != '0);

    assign push = in_valid && in_ready;
    assign pop  = upd_valid;                    // BTB takes one every cycle

    // Repack head entry into the BTB format
    assign head = mem[rd_ptr];
    always_comb begin
        upd.pc     = head.pc;
        upd.target = head.target;
        upd.taken  = head.taken;
    end

    // Storage, written on a handshake
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap since depth is a power of two
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;  // Fill
                end
                2'b01: begin
                    count <= count - 1'b1;  // Drain
                end
                default: begin
                    count <= count;         // Both or neither
                end
            endcase
        end
    end

endmodule

/* hw/fetch_pc_gen.sv */
module fetch_pc_gen (
    input  logic           CLK,
    input  logic           nRST,
    input  logic           fetch_ready,      // Fetch stage accepts
    input  logic           redirect_valid,   // Mispredict from execute
    input  bpu_pkg::word_t redirect_pc,      // Correct path PC
    input  logic           pred_hit_taken,   // Live BTB prediction
    input  bpu_pkg::word_t pred_target,      // Live BTB target
    output bpu_pkg::word_t lookup_pc,        // Address sent to the BTB
    output logic           fetch_valid,
    output bpu_pkg::word_t fetch_pc,
    output logic           fetch_pred_taken  // Prediction for fetch_pc
);
    import bpu_pkg::*;

    word_t pc_q;                             // Current fetch PC
    logic  valid_q;
    logic  held_valid;                       // Prediction latched during a stall
    logic  held_taken;
    word_t held_target;
    word_t cur_target;                       // Target paired with fetch_pred_taken
    word_t next_pc;
    logic  xfer;                             // Fetch handshake
    logic  stall;

    assign lookup_pc   = pc_q;
    assign fetch_pc    = pc_q;
    assign fetch_valid = valid_q;

    assign xfer  = valid_q && fetch_ready;
    assign stall = valid_q && !fetch_ready && !redirect_valid;

    // Freeze prediction once the PC has been shown, so training can't flip it mid-stall
    assign fetch_pred_taken = held_valid ? held_taken : pred_hit_taken;
    assign cur_target       = held_valid ? held_target : pred_target;

    // Next PC with redirect first
    always_comb begin
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else if (xfer) begin
            next_pc = fetch_pred_taken ? cur_target : pc_q + WORD_SIZE'(4);
        end else begin
            next_pc = pc_q;                  // Hold under back-pressure
        end
    end

    // PC and valid flag
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_q    <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= next_pc;
            valid_q <= 1'b1;                 // High from first edge on
        end
    end

    // Held flags clear once the PC moves
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_valid <= 1'b0;
            held_taken <= 1'b0;
        end else if (stall) begin
            held_valid <= 1'b1;
            held_taken <= fetch_pred_taken;
        end else begin
            held_valid <= 1'b0;
        end
    end

    // Target paired with the held prediction
    always_ff @(posedge CLK) begin
        if (stall) begin
            held_target <= cur_target;
        end
    end

endmodule

/* hw/bpu_top.sv */
module bpu_top (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              fetch_ready,     // Fetch stage back-pressure
    input  logic              resolve_valid,   // Resolved branch offered
    input  bpu_pkg::resolve_t resolve,         // Resolved branch data
    input  logic              redirect_valid,  // Mispredict redirect
    input  bpu_pkg::word_t    redirect_pc,     // Redirect destination
    output logic              fetch_valid,
    output bpu_pkg::word_t    fetch_pc,
    output logic              fetch_pred_taken,
    output logic              resolve_ready    // Queue has room
);
    import bpu_pkg::*;

    logic        upd_valid;                    // Queue head to BTB
    btb_update_t upd;
    word_t       lookup_pc;                    // PC gen to BTB
    logic        pred_hit_taken;               // BTB back to PC gen
    word_t       pred_target;

    // Training path
    resolve_queue u_resolve_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .in_valid  (resolve_valid),
        .in_data   (resolve),
        .in_ready  (resolve_ready),
        .upd_valid (upd_valid),
        .upd       (upd)
    );

    btb u_btb (
        .CLK            (CLK),
        .nRST           (nRST),
        .lookup_pc      (lookup_pc),
        .upd_valid      (upd_valid),
        .upd            (upd),
        .pred_hit_taken (pred_hit_taken),
        .pred_target    (pred_target)
    );

    // Fetch address path
    fetch_pc_gen u_fetch_pc_gen (
        .CLK              (CLK),
        .nRST             (nRST),
        .fetch_ready      (fetch_ready),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .pred_hit_taken   (pred_hit_taken),
        .pred_target      (pred_target),
        .lookup_pc        (lookup_pc),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_pred_taken (fetch_pred_taken)
    );

endmodule

/* verif/bpu_sva.sv */
module bpu_sva (
    input logic              CLK,
    input logic              nRST,
    input logic              fetch_ready,
    input logic              resolve_valid,
    input bpu_pkg::resolve_t resolve,
    input logic              redirect_valid,
    input bpu_pkg::word_t    redirect_pc,
    input logic              fetch_valid,
    input bpu_pkg::word_t    fetch_pc,
    input logic              fetch_pred_taken,
    input logic              resolve_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import bpu_pkg::*;

    logic [BTB_TAG_BITS-1:0] sh_tag [BTB_FRAMES];       // Shadow BTB frames
    word_t                   sh_target [BTB_FRAMES];
    ctr_state_t              sh_ctr [BTB_FRAMES];

    resolve_t                q_mem [RQ_DEPTH];          // Shadow resolve queue
    logic [RQ_PTR_BITS-1:0]  q_wr;
    logic [RQ_PTR_BITS-1:0]  q_rd;
    logic [RQ_CNT_BITS-1:0]  q_count;
    logic                    q_push;
    logic                    q_pop;
    resolve_t                head;
    btb_addr_t               ha;                        // Head PC split
    btb_addr_t               fa;                        // Fetch PC split

    logic                    stall;                     // Shown PC not taken and no redirect
    logic                    held_q;                    // Prediction frozen this cycle
    logic                    held_taken_q;
    word_t                   held_target_q;
    logic                    exp_taken;                 // Expected fetch_pred_taken
    word_t                   exp_target;                // Expected next PC when taken
    word_t                   last_pc;                   // Values seen at the last edge
    word_t                   last_redirect_pc;
    word_t                   last_target;
    logic                    last_pred;

    int                      fail_count = 0;            // Failed assertion count

    // Counter moves on a tag match
    function automatic ctr_state_t next_counter(ctr_state_t ctr, logic taken);
        case (ctr)
            SNT:     return taken ? WNT : SNT;
            WNT:     return taken ? ST : SNT;
            WT:      return taken ? ST : SNT;
            default: return taken ? ST : WT;
        endcase
    endfunction

    assign fa     = btb_addr_t'(fetch_pc);
    assign head   = q_mem[q_rd];
    assign ha     = btb_addr_t'(head.pc);
    assign q_push = resolve_valid && (q_count != RQ_CNT_BITS'(RQ_DEPTH));
    assign q_pop  = (q_count != '0);                    // Drains one per cycle
    assign stall  = fetch_valid && !fetch_ready && !redirect_valid;

    // Fresh PC looks up the shadow while a stalled one keeps its prediction
    always_comb begin
        if (held_q) begin
            exp_taken  = held_taken_q;
            exp_target = held_target_q;
        end else begin
            exp_taken  = (sh_tag[fa.idx] == fa.tag) && sh_ctr[fa.idx][CTR_BITS-1];
            exp_target = sh_target[fa.idx];
        end
    end

    always_ff @(posedge CLK) begin
        if (q_push) begin
            q_mem[q_wr] <= resolve;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q_wr    <= '0;
            q_rd    <= '0;
            q_count <= '0;
        end else begin
            if (q_push) begin
                q_wr <= q_wr + RQ_PTR_BITS'(1);
            end
            if (q_pop) begin
                q_rd <= q_rd + RQ_PTR_BITS'(1);
            end
            q_count <= q_count + RQ_CNT_BITS'(q_push) - RQ_CNT_BITS'(q_pop);
        end
    end

    // Shadow BTB trained by the queue head
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < BTB_FRAMES; i++) begin
                sh_tag[i]    <= '0;
                sh_target[i] <= '0;
                sh_ctr[i]    <= SNT;
            end
        end else if (q_pop) begin
            if (sh_tag[ha.idx] == ha.tag) begin
                sh_ctr[ha.idx] <= next_counter(sh_ctr[ha.idx], head.taken);
            end else begin
                sh_tag[ha.idx] <= ha.tag;               // Alias replaced
                sh_ctr[ha.idx] <= head.taken ? WT : WNT;
            end
            sh_target[ha.idx] <= head.target;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held_q           <= 1'b0;
            held_taken_q     <= 1'b0;
            held_target_q    <= '0;
            last_pc          <= '0;
            last_redirect_pc <= '0;
            last_target      <= '0;
            last_pred        <= 1'b0;
        end else begin
            held_q <= stall;
            if (stall) begin
                held_taken_q  <= exp_taken;
                held_target_q <= exp_target;
            end
            last_pc          <= fetch_pc;
            last_redirect_pc <= redirect_pc;
            last_target      <= exp_target;
            last_pred        <= fetch_pred_taken;
        end
    end

    a_reset_idle: assert property (@(posedge CLK) !nRST |-> !fetch_valid)
        else begin
            fail_count++;
            $error("ERR %0t fetch_valid exp 0 got %b", $time, $sampled(fetch_valid));
        end

    a_reset_ready: assert property (@(posedge CLK) !nRST |-> resolve_ready)
        else begin
            fail_count++;
            $error("ERR %0t resolve_ready exp 1 got %b", $time, $sampled(resolve_ready));
        end

    a_first_pc: assert property (@(posedge CLK) $rose(fetch_valid) |-> fetch_pc == RESET_PC)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pc exp %h got %h", $time, RESET_PC, $sampled(fetch_pc));
        end

    a_valid_hold: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_valid |=> fetch_valid)
        else begin
            fail_count++;
            $error("ERR %0t fetch_valid exp 1 got %b", $time, $sampled(fetch_valid));
        end

    a_seq_step: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_valid && fetch_ready && !fetch_pred_taken && !redirect_valid
        |=> fetch_pc == last_pc + WORD_SIZE'(4))
        else begin
            fail_count++;
            $error("ERR %0t fetch_pc exp %h got %h", $time,
                   $sampled(last_pc) + WORD_SIZE'(4), $sampled(fetch_pc));
        end

    a_redirect: assert property (@(posedge CLK) disable iff (!nRST)
        redirect_valid |=> fetch_pc == last_redirect_pc)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pc exp %h got %h", $time,
                   $sampled(last_redirect_pc), $sampled(fetch_pc));
        end

    a_pred: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_valid |-> fetch_pred_taken == exp_taken)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pred_taken exp %b got %b", $time,
                   $sampled(exp_taken), $sampled(fetch_pred_taken));
        end

    a_pred_target: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_valid && fetch_ready && fetch_pred_taken && !redirect_valid
        |=> fetch_pc == last_target)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pc exp %h got %h", $time,
                   $sampled(last_target), $sampled(fetch_pc));
        end

    a_stall_pc: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> fetch_pc == last_pc)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pc exp %h got %h", $time,
                   $sampled(last_pc), $sampled(fetch_pc));
        end

    a_stall_pred: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> fetch_pred_taken == last_pred)
        else begin
            fail_count++;
            $error("ERR %0t fetch_pred_taken exp %b got %b", $time,
                   $sampled(last_pred), $sampled(fetch_pred_taken));
        end

    a_queue_full: assert property (@(posedge CLK) disable iff (!nRST)
        resolve_ready == (q_count != RQ_CNT_BITS'(RQ_DEPTH)))
        else begin
            fail_count++;
            $error("ERR %0t resolve_ready exp %b got %b", $time,
                   $sampled(q_count != RQ_CNT_BITS'(RQ_DEPTH)), $sampled(resolve_ready));
        end

endmodule

bind bpu_top bpu_sva u_sva (
    .CLK              (CLK),
    .nRST             (nRST),
    .fetch_ready      (fetch_ready),
    .resolve_valid    (resolve_valid),
    .resolve          (resolve),
    .redirect_valid   (redirect_valid),
    .redirect_pc      (redirect_pc),
    .fetch_valid      (fetch_valid),
    .fetch_pc         (fetch_pc),
    .fetch_pred_taken (fetch_pred_taken),
    .resolve_ready    (resolve_ready)
);

/* verif/bpu_tb.sv */
module bpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import bpu_pkg::*;

    localparam int RESET_CYCLES  = 4;
    localparam int PHASE_CYCLES  = 250;
    localparam int NUM_PHASES    = 12;
    localparam int START_TIMEOUT = 8;                   // Cycles until fetch_valid
    localparam int OFFER_TIMEOUT = 16;                  // Cycles a resolve may wait
    localparam int DRAIN_TIMEOUT = 2 * RQ_DEPTH + 4;

    // Phase profiles: steady, stall heavy, redirect heavy, resolve burst
    localparam int READY_PCT [4]    = '{90, 35, 80, 60};
    localparam int RESOLVE_PCT [4]  = '{30, 50, 40, 95};
    localparam int REDIRECT_PCT [4] = '{4, 3, 15, 5};

    logic     CLK;
    logic     nRST;
    logic     fetch_ready;
    logic     resolve_valid;
    resolve_t resolve;
    logic     redirect_valid;
    word_t    redirect_pc;
    logic     fetch_valid;
    word_t    fetch_pc;
    logic     fetch_pred_taken;
    logic     resolve_ready;

    int       timeout_count;
    int       offer_age;                                // Cycles the current resolve waited
    logic     offer_taken;                              // Offer meets ready at the next edge

    // 0x208/0x608 and 0x210/0x610 share an index with different tags
    word_t pc_pool [8] = '{32'h0000_0200, 32'h0000_0208, 32'h0000_0210, 32'h0000_021c,
                           32'h0000_0608, 32'h0000_0610, 32'h0000_0228, 32'h0000_0600};
    word_t target_pool [4] = '{32'h0000_0200, 32'h0000_0600, 32'h0000_0210, 32'h0000_0608};

    bpu_top u_dut (
        .CLK              (CLK),
        .nRST             (nRST),
        .fetch_ready      (fetch_ready),
        .resolve_valid    (resolve_valid),
        .resolve          (resolve),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_pred_taken (fetch_pred_taken),
        .resolve_ready    (resolve_ready)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;                              // 8 ns period
        end
    end

    function automatic logic chance(int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic resolve_t random_resolve();
        resolve_t r;
        r.pc     = pc_pool[3'($urandom % 8)];
        r.target = target_pool[2'($urandom % 4)];
        r.taken  = chance(65);                          // Lean taken to reach ST
        return r;
    endfunction

    // All inputs change on the falling edge
    task automatic drive_cycle(input int ready_pct, input int resolve_pct, input int redirect_pct);
        @(negedge CLK);
        if (offer_taken) begin
            resolve_valid = 1'b0;                       // Accepted at the last edge
        end
        if (resolve_valid) begin
            offer_age++;
            if (offer_age > OFFER_TIMEOUT) begin
                $display("Timeout at %0t: resolve offer not accepted after %0d cycles",
                         $time, offer_age);
                timeout_count++;
                resolve_valid = 1'b0;
            end
        end
        if (!resolve_valid && chance(resolve_pct)) begin
            resolve_valid = 1'b1;
            resolve       = random_resolve();
            offer_age     = 0;
        end
        fetch_ready    = chance(ready_pct);
        redirect_valid = chance(redirect_pct);
        redirect_pc    = pc_pool[3'($urandom % 8)];
        offer_taken    = resolve_valid && resolve_ready; // Ready holds until the edge
    endtask

    initial begin : main_seq
        int waited;
        int phase;
        void'($urandom(56));
        nRST           = 1'b0;
        fetch_ready    = 1'b0;
        resolve_valid  = 1'b0;
        resolve        = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        timeout_count  = 0;
        offer_age      = 0;
        offer_taken    = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST   = 1'b1;
        waited = 0;
        while (!fetch_valid && waited < START_TIMEOUT) begin
            @(negedge CLK);
            waited++;
        end
        if (!fetch_valid) begin
            $display("Timeout: fetch_valid never rose after reset release");
            timeout_count++;
        end else begin
            for (phase = 0; phase < NUM_PHASES; phase++) begin
                repeat (PHASE_CYCLES) begin
                    drive_cycle(READY_PCT[2'(phase)], RESOLVE_PCT[2'(phase)],
                                REDIRECT_PCT[2'(phase)]);
                end
            end
            waited = 0;
            while ((resolve_valid || u_dut.upd_valid) && waited < DRAIN_TIMEOUT) begin
                drive_cycle(100, 0, 0);                 // No new offers, queue empties
                waited++;
            end
            if (resolve_valid || u_dut.upd_valid) begin
                $display("Timeout: resolve queue did not drain");
                timeout_count++;
            end
        end
        $display("Assertion failures: %0d, timeouts: %0d", u_dut.u_sva.fail_count,
                 timeout_count);
        if (u_dut.u_sva.fail_count == 0 && timeout_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/bpu_pkg.sv
hw/btb.sv
hw/resolve_queue.sv
hw/fetch_pc_gen.sv
hw/bpu_top.sv
verif/bpu_sva.sv
verif/bpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100000
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
